// ==== verilog/rec_pkg.sv ====
// Covers only the kept recovery commands; the FIFO depth is fixed here and must be a power of two
package rec_pkg;

  // Recovery command codes
  localparam logic [7:0] CmdDeviceReset  = 8'd37;
  localparam logic [7:0] CmdRecoveryCtrl = 8'd38;
  localparam logic [7:0] CmdFifoCtrl     = 8'd45;
  localparam logic [7:0] CmdFifoStatus   = 8'd46;
  localparam logic [7:0] CmdFifoData     = 8'd47;

  // Legal code range, and the highest code outside recovery mode
  localparam logic [7:0] CmdFirst      = 8'd34;
  localparam logic [7:0] CmdLast       = 8'd47;
  localparam logic [7:0] CmdLastNormal = 8'd39;

  // Read response lengths in bytes
  localparam logic [15:0] LenDeviceReset  = 16'd3;
  localparam logic [15:0] LenRecoveryCtrl = 16'd3;
  localparam logic [15:0] LenFifoCtrl     = 16'd6;
  localparam logic [15:0] LenFifoStatus   = 16'd20;

  localparam int unsigned IndirectFifoDepth = 16;
  localparam int unsigned IdxWidth          = $clog2(IndirectFifoDepth);

  localparam logic [7:0] ImageActivateCode = 8'h0F;
  localparam logic [7:0] FifoResetCode     = 8'd1;

  // Register word selector, consecutive words of one command are adjacent
  typedef enum logic [7:0] {
    SelDeviceReset  = 8'd0,
    SelRecoveryCtrl = 8'd1,
    SelFifoCtrl0    = 8'd2,
    SelFifoCtrl1    = 8'd3,
    SelFifoStatus0  = 8'd4,
    SelFifoStatus1  = 8'd5,
    SelFifoStatus2  = 8'd6,
    SelFifoStatus3  = 8'd7,
    SelFifoStatus4  = 8'd8,
    SelNone         = 8'hFF
  } reg_sel_e;

  typedef struct packed {
    logic [7:0] reserved;
    logic [7:0] if_ctrl;
    logic [7:0] forced_recovery;
    logic [7:0] reset_ctrl;
  } dev_reset_t;

  typedef struct packed {
    logic [7:0] reserved;
    logic [7:0] activate;
    logic [7:0] img_sel;
    logic [7:0] cms;
  } rec_ctrl_t;

  typedef struct packed {
    logic [15:0] image_size_msb;
    logic [7:0]  reset;
    logic [7:0]  cms;
  } fifo_ctrl_t;

  // One register word seen through each register layout
  typedef union packed {
    logic [31:0] raw;
    dev_reset_t  dev_reset;
    rec_ctrl_t   rec_ctrl;
    fifo_ctrl_t  fifo_ctrl;
  } rec_word_u;

endpackage

// ==== verilog/rec_csr_if.sv ====
// Register access between sequencer and register file; rdata is combinational for the current sel
`timescale 1ns/1ps

interface rec_csr_if;

  rec_pkg::reg_sel_e sel;
  logic              we;
  rec_pkg::rec_word_u wdata;
  rec_pkg::rec_word_u rdata;

  // Sequencer side
  modport fsm_mp (
    output sel,
    output we,
    output wdata,
    input  rdata
  );

  // Register file side
  modport csr_mp (
    input  sel,
    input  we,
    input  wdata,
    output rdata
  );

endinterface

// ==== verilog/rec_fifo_if.sv ====
// FIFO status toward the register file and the index clear back; clr is a one-cycle pulse
`timescale 1ns/1ps

interface rec_fifo_if;

  logic [rec_pkg::IdxWidth-1:0] wr_idx;
  logic [rec_pkg::IdxWidth-1:0] rd_idx;
  logic                         full;
  logic                         empty;
  logic                         clr;

  // FIFO side
  modport fifo_mp (
    output wr_idx,
    output rd_idx,
    output full,
    output empty,
    input  clr
  );

  // Register file side
  modport csr_mp (
    input  wr_idx,
    input  rd_idx,
    input  full,
    input  empty,
    output clr
  );

endinterface

// ==== verilog/rec_cmd_fsm.sv ====
// One command at a time; extra write words past the writable registers are taken and dropped
`timescale 1ns/1ps

module rec_cmd_fsm (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cmd_valid_i,
  input  logic        cmd_is_rd_i,
  input  logic [7:0]  cmd_cmd_i,
  input  logic [15:0] cmd_len_i,
  input  logic        cmd_error_i,
  input  logic        recovery_mode_i,
  output logic        cmd_done_o,
  output logic        res_valid_o,
  input  logic        res_ready_i,
  output logic [15:0] res_len_o,
  output logic        res_dvalid_o,
  input  logic        res_dready_i,
  output logic [7:0]  res_data_o,
  output logic        res_dlast_o,
  output logic        rx_rreq_o,
  input  logic        rx_rack_i,
  input  logic [31:0] rx_rdata_i,
  output logic        rx_queue_clr_o,
  output logic        push_o,
  output logic [31:0] push_data_o,
  rec_csr_if.fsm_mp   csr
);

  typedef enum logic [2:0] {
    Idle,
    Write,
    FifoWrite,
    ReadHdr,
    ReadData,
    Error,
    Done
  } state_e;

  state_e            state_q, state_d;
  rec_pkg::reg_sel_e sel_q, start_sel, next_sel;
  logic [15:0]       len_q, start_len;
  logic [15:0]       words_q, num_words;
  logic [15:0]       bytes_q;
  logic [1:0]        wr_left_q, start_wr;
  logic              supported, cmd_bad;
  logic              rreq_q;
  logic              rx_take, byte_take, last_byte;

  // Per-code start selector, read length and writable word count
  always_comb begin
    start_sel = rec_pkg::SelNone;
    start_len = '0;
    start_wr  = '0;
    supported = 1'b1;
    case (cmd_cmd_i)
      rec_pkg::CmdDeviceReset: begin
        start_sel = rec_pkg::SelDeviceReset;
        start_len = rec_pkg::LenDeviceReset;
        start_wr  = 2'd1;
      end
      rec_pkg::CmdRecoveryCtrl: begin
        start_sel = rec_pkg::SelRecoveryCtrl;
        start_len = rec_pkg::LenRecoveryCtrl;
        start_wr  = 2'd1;
      end
      rec_pkg::CmdFifoCtrl: begin
        start_sel = rec_pkg::SelFifoCtrl0;
        start_len = rec_pkg::LenFifoCtrl;
        start_wr  = 2'd2;
      end
      rec_pkg::CmdFifoStatus: begin
        start_sel = rec_pkg::SelFifoStatus0;
        start_len = rec_pkg::LenFifoStatus;
      end
      // Image data only flows in
      rec_pkg::CmdFifoData: supported = !cmd_is_rd_i;
      default: supported = 1'b0;
    endcase
  end

  assign cmd_bad = cmd_error_i || (cmd_cmd_i < rec_pkg::CmdFirst) ||
                   (cmd_cmd_i > rec_pkg::CmdLast) || !supported ||
                   (!recovery_mode_i && (cmd_cmd_i > rec_pkg::CmdLastNormal));

  // Payload words, rounded up
  assign num_words = {2'b00, cmd_len_i[15:2]} + {15'd0, |cmd_len_i[1:0]};

  assign rx_take   = rx_rack_i && (words_q != '0) &&
                     ((state_q == Write) || (state_q == FifoWrite));
  assign byte_take = (state_q == ReadData) && res_dready_i;
  assign last_byte = (bytes_q == len_q - 16'd1);

  // Selector saturates at SelNone past the last register word
  assign next_sel = (sel_q >= rec_pkg::SelFifoStatus4) ? rec_pkg::SelNone
                                                        : rec_pkg::reg_sel_e'(sel_q + 8'd1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (cmd_valid_i) begin
          if (cmd_bad) begin
            state_d = Error;
          end else if (cmd_is_rd_i) begin
            state_d = ReadHdr;
          end else if (cmd_cmd_i == rec_pkg::CmdFifoData) begin
            state_d = FifoWrite;
          end else begin
            state_d = Write;
          end
        end
      end
      Write, FifoWrite: begin
        if (words_q == '0 || (rx_take && words_q == 16'd1)) begin
          state_d = Done;
        end
      end
      ReadHdr:  if (res_ready_i) state_d = ReadData;
      ReadData: if (byte_take && last_byte) state_d = Done;
      Error:    state_d = Done;
      default:  state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= Idle;
      sel_q     <= rec_pkg::SelNone;
      len_q     <= '0;
      words_q   <= '0;
      bytes_q   <= '0;
      wr_left_q <= '0;
      rreq_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      rreq_q  <= 1'b0;
      if (state_q == Idle && cmd_valid_i) begin
        sel_q     <= start_sel;
        len_q     <= start_len;
        words_q   <= num_words;
        bytes_q   <= '0;
        wr_left_q <= start_wr;
        rreq_q    <= !cmd_bad && !cmd_is_rd_i && (num_words != '0);
      end
      if (rx_take) begin
        words_q <= words_q - 16'd1;
        sel_q   <= next_sel;
        // Next request one cycle after each ack
        rreq_q  <= (words_q != 16'd1);
        if (wr_left_q != '0) wr_left_q <= wr_left_q - 2'd1;
      end
      if (byte_take) begin
        bytes_q <= bytes_q + 16'd1;
        if (bytes_q[1:0] == 2'd3) sel_q <= next_sel;
      end
    end
  end

  assign csr.sel   = sel_q;
  assign csr.we    = rx_take && (state_q == Write) && (wr_left_q != '0);
  assign csr.wdata = rx_rdata_i;

  assign push_o      = rx_take && (state_q == FifoWrite);
  assign push_data_o = rx_rdata_i;
  assign rx_rreq_o   = rreq_q;

  assign rx_queue_clr_o = (state_q == Error);
  assign cmd_done_o     = (state_q == Done);

  assign res_valid_o  = (state_q == ReadHdr);
  assign res_len_o    = len_q;
  assign res_dvalid_o = (state_q == ReadData);
  assign res_dlast_o  = (state_q == ReadData) && last_byte;
  // Low byte first
  assign res_data_o   = csr.rdata.raw[{bytes_q[1:0], 3'b000} +: 8];

endmodule

// ==== verilog/rec_csr_file.sv ====
// Writable recovery registers plus FIFO status words; the FIFO reset byte always reads back as 0
`timescale 1ns/1ps

module rec_csr_file (
  input  logic        clk_i,
  input  logic        rst_ni,
  rec_csr_if.csr_mp   csr,
  rec_fifo_if.csr_mp  fifo,
  output logic        image_activated_o
);

  rec_pkg::rec_word_u dev_reset_q;
  rec_pkg::rec_word_u rec_ctrl_q;
  rec_pkg::rec_word_u fifo_ctrl0_q;
  logic [15:0]        image_size_lsb_q;
  logic               clr_q;
  logic               fifo_rst_wr;

  assign fifo_rst_wr = csr.we && (csr.sel == rec_pkg::SelFifoCtrl0) &&
                       (csr.wdata.fifo_ctrl.reset == rec_pkg::FifoResetCode);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dev_reset_q      <= '0;
      rec_ctrl_q       <= '0;
      fifo_ctrl0_q     <= '0;
      image_size_lsb_q <= '0;
      clr_q            <= 1'b0;
    end else begin
      clr_q <= fifo_rst_wr;
      if (csr.we) begin
        case (csr.sel)
          rec_pkg::SelDeviceReset: begin
            dev_reset_q.dev_reset.if_ctrl         <= csr.wdata.dev_reset.if_ctrl;
            dev_reset_q.dev_reset.forced_recovery <= csr.wdata.dev_reset.forced_recovery;
            dev_reset_q.dev_reset.reset_ctrl      <= csr.wdata.dev_reset.reset_ctrl;
          end
          rec_pkg::SelRecoveryCtrl: begin
            rec_ctrl_q.rec_ctrl.activate <= csr.wdata.rec_ctrl.activate;
            rec_ctrl_q.rec_ctrl.img_sel  <= csr.wdata.rec_ctrl.img_sel;
            rec_ctrl_q.rec_ctrl.cms      <= csr.wdata.rec_ctrl.cms;
          end
          // Reset byte is an action only, never stored
          rec_pkg::SelFifoCtrl0: begin
            fifo_ctrl0_q.fifo_ctrl.image_size_msb <= csr.wdata.fifo_ctrl.image_size_msb;
            fifo_ctrl0_q.fifo_ctrl.cms            <= csr.wdata.fifo_ctrl.cms;
          end
          rec_pkg::SelFifoCtrl1: image_size_lsb_q <= csr.wdata.raw[15:0];
          default: ;
        endcase
      end
    end
  end

  // Read word for the current selector
  always_comb begin
    csr.rdata = '0;
    case (csr.sel)
      rec_pkg::SelDeviceReset:  csr.rdata = dev_reset_q;
      rec_pkg::SelRecoveryCtrl: csr.rdata = rec_ctrl_q;
      rec_pkg::SelFifoCtrl0:    csr.rdata = fifo_ctrl0_q;
      rec_pkg::SelFifoCtrl1:    csr.rdata.raw = {16'd0, image_size_lsb_q};
      rec_pkg::SelFifoStatus0:  csr.rdata.raw = {30'd0, fifo.full, fifo.empty};
      rec_pkg::SelFifoStatus1:  csr.rdata.raw = 32'(fifo.wr_idx);
      rec_pkg::SelFifoStatus2:  csr.rdata.raw = 32'(fifo.rd_idx);
      rec_pkg::SelFifoStatus3:  csr.rdata.raw = 32'(rec_pkg::IndirectFifoDepth);
      default:                  csr.rdata = '0;
    endcase
  end

  assign fifo.clr          = clr_q;
  assign image_activated_o = (rec_ctrl_q.rec_ctrl.activate == rec_pkg::ImageActivateCode);

endmodule

// ==== verilog/rec_indirect_fifo.sv ====
// Pushes into a full FIFO are dropped and reads of an empty FIFO are ignored; clr wins over both
`timescale 1ns/1ps

module rec_indirect_fifo (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        push_i,
  input  logic [31:0] push_data_i,
  input  logic        fifo_rreq_i,
  output logic        fifo_rvalid_o,
  output logic [31:0] fifo_rdata_o,
  output logic        payload_available_o,
  rec_fifo_if.fifo_mp fifo
);

  logic [31:0]                  mem [rec_pkg::IndirectFifoDepth];
  logic [rec_pkg::IdxWidth-1:0] wr_idx_q, rd_idx_q;
  logic [rec_pkg::IdxWidth:0]   count_q, count_d;
  logic                         push_ok, pop_ok;
  logic                         rvalid_q, payload_q;

  assign fifo.full  = (count_q == (rec_pkg::IdxWidth + 1)'(rec_pkg::IndirectFifoDepth));
  assign fifo.empty = (count_q == '0);

  assign push_ok = push_i && !fifo.full;
  assign pop_ok  = fifo_rreq_i && !fifo.empty;

  always_comb begin
    count_d = count_q;
    if (fifo.clr) begin
      count_d = '0;
    end else if (push_ok && !pop_ok) begin
      count_d = count_q + 1'b1;
    end else if (pop_ok && !push_ok) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_idx_q  <= '0;
      rd_idx_q  <= '0;
      count_q   <= '0;
      rvalid_q  <= 1'b0;
      payload_q <= 1'b0;
    end else begin
      count_q  <= count_d;
      rvalid_q <= pop_ok;
      // Set by new data, dropped once drained or cleared
      payload_q <= (count_d != '0) && (payload_q || push_ok);
      if (fifo.clr) begin
        wr_idx_q <= '0;
        rd_idx_q <= '0;
      end else begin
        if (push_ok) begin
          wr_idx_q <= (wr_idx_q == (rec_pkg::IdxWidth)'(rec_pkg::IndirectFifoDepth - 1))
                      ? '0 : wr_idx_q + 1'b1;
        end
        if (pop_ok) begin
          rd_idx_q <= (rd_idx_q == (rec_pkg::IdxWidth)'(rec_pkg::IndirectFifoDepth - 1))
                      ? '0 : rd_idx_q + 1'b1;
        end
      end
    end
  end

  // Storage and read word
  always_ff @(posedge clk_i) begin
    if (push_ok) mem[wr_idx_q] <= push_data_i;
    if (pop_ok) fifo_rdata_o <= mem[rd_idx_q];
  end

  assign fifo.wr_idx        = wr_idx_q;
  assign fifo.rd_idx        = rd_idx_q;
  assign fifo_rvalid_o      = rvalid_q;
  assign payload_available_o = payload_q;

endmodule

// ==== verilog/recovery_executor.sv ====
// Commands arrive already decoded; the command source must wait for cmd_done_o before the next
`timescale 1ns/1ps

module recovery_executor (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Decoded command
  input  logic        cmd_valid_i,
  input  logic        cmd_is_rd_i,
  input  logic [7:0]  cmd_cmd_i,
  input  logic [15:0] cmd_len_i,
  input  logic        cmd_error_i,
  input  logic        recovery_mode_i,
  output logic        cmd_done_o,
  // Read response
  output logic        res_valid_o,
  input  logic        res_ready_i,
  output logic [15:0] res_len_o,
  output logic        res_dvalid_o,
  input  logic        res_dready_i,
  output logic [7:0]  res_data_o,
  output logic        res_dlast_o,
  // RX data queue
  output logic        rx_rreq_o,
  input  logic        rx_rack_i,
  input  logic [31:0] rx_rdata_i,
  output logic        rx_queue_clr_o,
  // Firmware side of the indirect FIFO
  input  logic        fifo_rreq_i,
  output logic        fifo_rvalid_o,
  output logic [31:0] fifo_rdata_o,
  output logic        payload_available_o,
  output logic        image_activated_o
);

  logic        push;
  logic [31:0] push_data;

  rec_csr_if  csr_if ();
  rec_fifo_if fifo_if ();

  rec_cmd_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_is_rd_i     (cmd_is_rd_i),
    .cmd_cmd_i       (cmd_cmd_i),
    .cmd_len_i       (cmd_len_i),
    .cmd_error_i     (cmd_error_i),
    .recovery_mode_i (recovery_mode_i),
    .cmd_done_o      (cmd_done_o),
    .res_valid_o     (res_valid_o),
    .res_ready_i     (res_ready_i),
    .res_len_o       (res_len_o),
    .res_dvalid_o    (res_dvalid_o),
    .res_dready_i    (res_dready_i),
    .res_data_o      (res_data_o),
    .res_dlast_o     (res_dlast_o),
    .rx_rreq_o       (rx_rreq_o),
    .rx_rack_i       (rx_rack_i),
    .rx_rdata_i      (rx_rdata_i),
    .rx_queue_clr_o  (rx_queue_clr_o),
    .push_o          (push),
    .push_data_o     (push_data),
    .csr             (csr_if.fsm_mp)
  );

  rec_csr_file u_csr (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .csr               (csr_if.csr_mp),
    .fifo              (fifo_if.csr_mp),
    .image_activated_o (image_activated_o)
  );

  rec_indirect_fifo u_fifo (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .push_i              (push),
    .push_data_i         (push_data),
    .fifo_rreq_i         (fifo_rreq_i),
    .fifo_rvalid_o       (fifo_rvalid_o),
    .fifo_rdata_o        (fifo_rdata_o),
    .payload_available_o (payload_available_o),
    .fifo                (fifo_if.fifo_mp)
  );

endmodule

// ==== tb/rec_executor_sva.sv ====
// Checks only the top-level handshakes; error_count is read by the testbench after each failure
`timescale 1ns/1ps

module rec_executor_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic cmd_done_o,
  input logic res_dvalid_o,
  input logic res_dlast_o,
  input logic rx_rreq_o
);

  int error_count = 0;

  // Last flag only on a valid byte
  dlast_needs_dvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_dlast_o |-> res_dvalid_o)
    else begin
      $error("res_dlast_o high without res_dvalid_o");
      error_count++;
    end

  done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_done_o |=> !cmd_done_o)
    else begin
      $error("cmd_done_o held for more than one cycle");
      error_count++;
    end

  // A read never overlaps with RX requests
  no_rreq_in_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_dvalid_o |-> !rx_rreq_o)
    else begin
      $error("rx_rreq_o raised while streaming response bytes");
      error_count++;
    end

endmodule

bind recovery_executor rec_executor_sva u_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .cmd_done_o   (cmd_done_o),
  .res_dvalid_o (res_dvalid_o),
  .res_dlast_o  (res_dlast_o),
  .rx_rreq_o    (rx_rreq_o)
);

// ==== tb/tb_recovery_executor.sv ====
// Must run from the project root, since the test data path tb/rec_testdata.txt is relative
`timescale 1ns/1ps

module tb_recovery_executor;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        cmd_valid_i;
  logic        cmd_is_rd_i;
  logic [7:0]  cmd_cmd_i;
  logic [15:0] cmd_len_i;
  logic        cmd_error_i;
  logic        recovery_mode_i;
  logic        cmd_done_o;
  logic        res_valid_o;
  logic        res_ready_i;
  logic [15:0] res_len_o;
  logic        res_dvalid_o;
  logic        res_dready_i;
  logic [7:0]  res_data_o;
  logic        res_dlast_o;
  logic        rx_rreq_o;
  logic        rx_rack_i;
  logic [31:0] rx_rdata_i;
  logic        rx_queue_clr_o;
  logic        fifo_rreq_i;
  logic        fifo_rvalid_o;
  logic [31:0] fifo_rdata_o;
  logic        payload_available_o;
  logic        image_activated_o;

  // Fields of the current data file entry
  logic [7:0]       kind;
  int               arg0;
  int               arg1;
  int               arg2;
  logic [31:0]      vals[$];
  logic [8*128-1:0] skip_buf;

  logic [31:0] rx_words[$];
  logic [7:0]  got_bytes[$];
  logic        got_last[$];
  logic [15:0] hdr_len;
  logic        saw_clr;
  logic        saw_hdr;
  logic [31:0] rx_rng = 32'd46;
  logic [31:0] hdr_rng = 32'd46;
  logic [31:0] dat_rng = 32'd46;
  int          cycles = 0;
  int          cycle_limit = 100;

  recovery_executor u_recovery_executor (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Outputs are settled 1 ns after the edge, inputs change there too
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %02h expected %02h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input rec_pkg::rec_word_u got, input rec_pkg::rec_word_u exp,
                            input string what);
    if (got.raw !== exp.raw) begin
      $display("MISMATCH at %0t: %s got %08h expected %08h", $time, what, got.raw, exp.raw);
      abort_run();
    end
  endtask

  task automatic check_len(input logic [15:0] got, input logic [15:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // One entry per call, comment lines skipped
  task automatic read_entry(input int fd, output bit ok);
    int          rc;
    int          n;
    int          i;
    logic [31:0] v;
    ok = 1'b0;
    n = 0;
    vals.delete();
    rc = $fscanf(fd, " %c", kind);
    while (rc == 1 && kind == "#") begin
      rc = $fgets(skip_buf, fd);
      rc = $fscanf(fd, " %c", kind);
    end
    if (rc == 1) begin
      case (kind)
        "M": rc = $fscanf(fd, "%d", arg0);
        "W": rc = $fscanf(fd, "%d %d %d", arg0, arg1, n);
        "R": rc = $fscanf(fd, "%d %d", arg0, n);
        "E": rc = $fscanf(fd, "%d %d %d", arg0, arg1, arg2);
        "D": rc = $fscanf(fd, "%d", n);
        "F": rc = $fscanf(fd, "%d %d", arg0, arg1);
        default: begin
          $display("Unknown entry kind '%c' in the test data file", kind);
          abort_run();
        end
      endcase
      for (i = 0; i < n; i++) begin
        rc = $fscanf(fd, "%h", v);
        vals.push_back(v);
      end
      ok = 1'b1;
    end
  endtask

  task automatic issue_cmd(input logic [7:0] code, input logic is_rd, input logic [15:0] len,
                           input logic err);
    got_bytes.delete();
    got_last.delete();
    hdr_len = '0;
    cmd_cmd_i = code;
    cmd_is_rd_i = is_rd;
    cmd_len_i = len;
    cmd_error_i = err;
    cmd_valid_i = 1'b1;
    next_cycle();
    cmd_valid_i = 1'b0;
    cmd_error_i = 1'b0;
    saw_clr = 1'b0;
    saw_hdr = 1'b0;
    while (!cmd_done_o) begin
      saw_clr = saw_clr | rx_queue_clr_o;
      saw_hdr = saw_hdr | res_valid_o;
      next_cycle();
    end
    // Back to idle before the next command
    next_cycle();
  endtask

  task automatic run_entry();
    int i;
    case (kind)
      "M": recovery_mode_i = arg0[0];
      "W": begin
        rx_words = vals;
        issue_cmd(arg0[7:0], 1'b0, arg1[15:0], 1'b0);
        check_flag(rx_words.size() == 0, 1'b1, "all RX words taken by the write");
      end
      "R": begin
        issue_cmd(arg0[7:0], 1'b1, 16'd0, 1'b0);
        check_len(hdr_len, 16'(vals.size()), "res_len_o");
        if (got_bytes.size() != vals.size()) begin
          $display("Read of command %0d returned %0d bytes instead of %0d", arg0,
                   got_bytes.size(), vals.size());
          abort_run();
        end else begin
          for (i = 0; i < vals.size(); i++) begin
            check_byte(got_bytes[i], vals[i][7:0], "response byte");
            check_flag(got_last[i], i == vals.size() - 1, "res_dlast_o");
          end
        end
      end
      "E": begin
        // One payload word waits in the queue and must never reach a register
        rx_words.delete();
        rx_words.push_back(32'hffff_ffff);
        issue_cmd(arg0[7:0], arg1[0], 16'd4, arg2[0]);
        check_flag(saw_clr, 1'b1, "rx_queue_clr_o on an error command");
        check_flag(saw_hdr, 1'b0, "res_valid_o on an error command");
        check_flag(rx_words.size() == 1, 1'b1, "RX word left in the queue by an error command");
        rx_words.delete();
      end
      "D": begin
        // Word arrives one cycle after each request
        for (i = 0; i < vals.size(); i++) begin
          fifo_rreq_i = 1'b1;
          next_cycle();
          fifo_rreq_i = 1'b0;
          check_flag(fifo_rvalid_o, 1'b1, "fifo_rvalid_o after a firmware read");
          check_word(fifo_rdata_o, vals[i], "indirect FIFO word");
        end
      end
      "F": begin
        if (arg0 == 0) begin
          check_flag(payload_available_o, arg1[0], "payload_available_o");
        end else begin
          check_flag(image_activated_o, arg1[0], "image_activated_o");
        end
      end
      default: ;
    endcase
  endtask

  // RX queue answers each request after 1 to 3 cycles
  initial begin : rx_queue_model
    rx_rack_i = 1'b0;
    rx_rdata_i = '0;
    forever begin
      next_cycle();
      rx_rack_i = 1'b0;
      if (rx_rreq_o) begin
        rx_rng = xorshift32(rx_rng);
        repeat (rx_rng % 3) next_cycle();
        if (rx_words.size() == 0) begin
          $display("RX queue model got a request with no word left");
          abort_run();
        end else begin
          rx_rdata_i = rx_words.pop_front();
          rx_rack_i = 1'b1;
        end
      end
    end
  end

  initial begin : hdr_ready_model
    res_ready_i = 1'b0;
    forever begin
      next_cycle();
      res_ready_i = 1'b0;
      if (res_valid_o) begin
        hdr_rng = xorshift32(hdr_rng);
        repeat (hdr_rng % 3) next_cycle();
        hdr_len = res_len_o;
        res_ready_i = 1'b1;
      end
    end
  end

  initial begin : data_ready_model
    res_dready_i = 1'b0;
    forever begin
      next_cycle();
      res_dready_i = 1'b0;
      if (res_dvalid_o) begin
        dat_rng = xorshift32(dat_rng);
        repeat (dat_rng % 3) next_cycle();
        got_bytes.push_back(res_data_o);
        got_last.push_back(res_dlast_o);
        res_dready_i = 1'b1;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles without finishing the test data", cycles);
      abort_run();
    end else if (u_recovery_executor.u_sva.error_count != 0) begin
      $display("A handshake assertion failed at %0t", $time);
      abort_run();
    end
  end

  initial begin : main_flow
    int fd;
    int n_entries;
    bit ok;
    rst_ni = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_is_rd_i = 1'b0;
    cmd_cmd_i = '0;
    cmd_len_i = '0;
    cmd_error_i = 1'b0;
    recovery_mode_i = 1'b0;
    fifo_rreq_i = 1'b0;
    fd = $fopen("tb/rec_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tb/rec_testdata.txt");
      abort_run();
    end
    // First pass only sizes the cycle limit
    n_entries = 0;
    read_entry(fd, ok);
    while (ok) begin
      n_entries++;
      read_entry(fd, ok);
    end
    $fclose(fd);
    cycle_limit = 200 * n_entries + 100;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    next_cycle();
    fd = $fopen("tb/rec_testdata.txt", "r");
    read_entry(fd, ok);
    while (ok) begin
      run_entry();
      read_entry(fd, ok);
    end
    $fclose(fd);
    if (u_recovery_executor.u_sva.error_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("A handshake assertion failed during the run");
      abort_run();
    end
  end

endmodule

// ==== tb/rec_testdata.txt ====
# M mode | W code len n words | R code n bytes | E code is_rd err | D n words | F flag value
# Codes and counts decimal, data hex; flag 0 is payload_available_o, 1 is image_activated_o
M 1
W 38 4 1 000f0203
R 38 3 03 02 0f
F 1 1
W 37 8 2 11223344 55667788
R 37 3 44 33 22
W 47 12 3 a1a2a3a4 b1b2b3b4 c1c2c3c4
F 0 1
R 46 20 00 00 00 00 03 00 00 00 00 00 00 00 10 00 00 00 00 00 00 00
D 3 a1a2a3a4 b1b2b3b4 c1c2c3c4
F 0 0
R 46 20 01 00 00 00 03 00 00 00 03 00 00 00 10 00 00 00 00 00 00 00
W 45 8 2 12340105 00005678
R 46 20 01 00 00 00 00 00 00 00 00 00 00 00 10 00 00 00 00 00 00 00
R 45 6 05 00 34 12 78 56
E 38 0 1
E 50 0 0
E 44 1 0
M 0
E 45 0 0
M 1
R 38 3 03 02 0f
R 45 6 05 00 34 12 78 56

// ==== src.f ====
verilog/rec_pkg.sv
verilog/rec_csr_if.sv
verilog/rec_fifo_if.sv
verilog/rec_cmd_fsm.sv
verilog/rec_csr_file.sv
verilog/rec_indirect_fifo.sv
verilog/recovery_executor.sv
tb/rec_executor_sva.sv
tb/tb_recovery_executor.sv
